// ==== hw/chip_consts.svh ====
`ifndef CHIP_CONSTS_SVH
`define CHIP_CONSTS_SVH

// number of populated user design slots behind the GPIO mux
// slot numbering starts at 1 so that the slot index equals design_select
`define NUM_DESIGNS 3

// cycles a freshly selected slot spends counting in its wait state
// the design leaves reset on the (RESET_HOLD+1)th edge after selection
`define RESET_HOLD 4

// reset value of the noise source, must never be all zeros
`define LFSR_SEED 16'hACE1

// Galois feedback mask applied when the bit shifted out is a one
// this mask gives a maximal length sequence of 65535 states
`define LFSR_TAPS 16'hB400

`endif

// ==== hw/chip_pkg.sv ====
package chip_pkg;

    // one full GPIO bank, 34 pins, shared by every design and the mux
    // oeb bits are active low, so a 1 leaves the pin as an input
    typedef logic [33:0] gpio_t;

    // per-slot reset sequencing states kept by the reset router
    typedef enum logic [1:0] {
        // slot is not selected and sits in reset
        SLOT_HELD = 2'b00,
        // slot was just selected and is counting its hold cycles
        SLOT_WAIT = 2'b01,
        // slot is released and its design runs
        SLOT_RUN  = 2'b10
    } slot_state_t;

    // opcode driven on gpio_in[9:8] of the ALU design
    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_SUB = 2'b01,
        ALU_AND = 2'b10,
        ALU_XOR = 2'b11
    } alu_op_t;

endpackage

// ==== hw/reset_router.sv ====
`timescale 1ns/100ps
`include "chip_consts.svh"

module reset_router (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`NUM_DESIGNS:1] designs_cs,
    output logic [`NUM_DESIGNS:1] designs_rst_n
);

    import chip_pkg::*;

    // wide enough to count to RESET_HOLD-1 for any sane hold value
    localparam int HOLD_W = $clog2(`RESET_HOLD + 1);

    // one state register and one hold counter per slot
    slot_state_t       slot_state [`NUM_DESIGNS:1];
    logic [HOLD_W-1:0] hold_cnt   [`NUM_DESIGNS:1];

    // every slot runs the same sequence, held until its cs drops,
    // then RESET_HOLD edges of waiting, then run until cs rises again
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 1; k <= `NUM_DESIGNS; k++) begin
                slot_state[k] <= SLOT_HELD;
                hold_cnt[k]   <= '0;
            end
        end else begin
            for (int k = 1; k <= `NUM_DESIGNS; k++) begin
                if (designs_cs[k]) begin
                    // deselection drops the slot back into reset at this edge
                    slot_state[k] <= SLOT_HELD;
                    hold_cnt[k]   <= '0;
                end else begin
                    case (slot_state[k])
                        SLOT_HELD: begin
                            slot_state[k] <= SLOT_WAIT;
                            hold_cnt[k]   <= '0;
                        end
                        SLOT_WAIT: begin
                            // the edge that enters wait counts as the first one
                            if (hold_cnt[k] == HOLD_W'(`RESET_HOLD - 1)) begin
                                slot_state[k] <= SLOT_RUN;
                            end else begin
                                hold_cnt[k] <= hold_cnt[k] + 1'b1;
                            end
                        end
                        SLOT_RUN: begin
                            slot_state[k] <= SLOT_RUN;
                        end
                        default: begin
                            slot_state[k] <= SLOT_HELD;
                        end
                    endcase
                end
            end
        end
    end

    // a design leaves reset exactly when its slot reaches run
    always_comb begin
        for (int k = 1; k <= `NUM_DESIGNS; k++) begin
            designs_rst_n[k] = (slot_state[k] == SLOT_RUN);
        end
    end

    // only one design may ever be out of reset, otherwise two designs
    // would be fighting over the shared pins behind the mux
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(designs_rst_n));

    // a running slot has kept its cs low through the whole hold, so its cs
    // was already low at the selecting edge RESET_HOLD+1 edges back
    for (genvar g = 1; g <= `NUM_DESIGNS; g++) begin : g_run_check
        assert property (@(posedge clk) disable iff (!rst_n)
            (slot_state[g] == SLOT_RUN) |-> !$past(designs_cs[g], `RESET_HOLD + 1));
    end

endmodule

// ==== hw/counter_design.sv ====
`timescale 1ns/100ps

module counter_design (
    input  logic           clk,
    input  logic           rst_n,
    input  chip_pkg::gpio_t gpio_in,
    output chip_pkg::gpio_t gpio_out,
    output chip_pkg::gpio_t gpio_oeb
);

    import chip_pkg::*;

    // the count leaves on pins 15..8, everything else stays an input
    localparam gpio_t OEB_MAP = ~gpio_t'(34'h0_0000_FF00);

    logic [7:0] count;
    logic       count_en;
    logic       count_clr;

    // pin 0 is the enable, pin 1 the synchronous clear
    assign count_en  = gpio_in[0];
    assign count_clr = gpio_in[1];

    // clear wins over enable, the count wraps naturally at 8 bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (count_clr) begin
            count <= '0;
        end else if (count_en) begin
            count <= count + 8'd1;
        end
    end

    // unused outputs are driven low so the bank sees clean zeros
    always_comb begin
        gpio_out       = '0;
        gpio_out[15:8] = count;
        gpio_oeb       = OEB_MAP;
    end

    // a count bit may only show up on a pin that the pin map drives as an output
    assert property (@(posedge clk) (gpio_out & gpio_oeb) == '0);

endmodule

// ==== hw/lfsr_design.sv ====
`timescale 1ns/100ps
`include "chip_consts.svh"

module lfsr_design (
    input  logic           clk,
    input  logic           rst_n,
    input  chip_pkg::gpio_t gpio_in,
    output chip_pkg::gpio_t gpio_out,
    output chip_pkg::gpio_t gpio_oeb
);

    import chip_pkg::*;

    // the state leaves on pins 31..16
    localparam gpio_t OEB_MAP = ~gpio_t'(34'h0_FFFF_0000);

    logic [15:0] lfsr_state;
    logic [15:0] lfsr_next;
    logic        lfsr_step;

    // pin 0 advances the generator by one step per edge
    assign lfsr_step = gpio_in[0];

    // Galois form, the bit falling out of the bottom decides whether
    // the tap mask is folded back into the shifted value
    always_comb begin
        lfsr_next = lfsr_state >> 1;
        if (lfsr_state[0]) begin
            lfsr_next = lfsr_next ^ `LFSR_TAPS;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_state <= `LFSR_SEED;
        end else if (lfsr_step) begin
            lfsr_state <= lfsr_next;
        end
    end

    always_comb begin
        gpio_out        = '0;
        gpio_out[31:16] = lfsr_state;
        gpio_oeb        = OEB_MAP;
    end

    // zero is the lock-up state of the generator and must be unreachable
    assert property (@(posedge clk) disable iff (!rst_n) lfsr_state != 16'h0000);

endmodule

// ==== hw/alu_design.sv ====
`timescale 1ns/100ps

module alu_design (
    input  logic           clk,
    input  logic           rst_n,
    input  chip_pkg::gpio_t gpio_in,
    output chip_pkg::gpio_t gpio_out,
    output chip_pkg::gpio_t gpio_oeb
);

    import chip_pkg::*;

    // the 5-bit result leaves on pins 20..16
    localparam gpio_t OEB_MAP = ~gpio_t'(34'h0_001F_0000);

    logic [3:0] op_a;
    logic [3:0] op_b;
    alu_op_t    op;
    logic [4:0] result_next;
    logic [4:0] result;

    // operands and opcode come straight off the input pins
    assign op_a = gpio_in[3:0];
    assign op_b = gpio_in[7:4];
    assign op   = alu_op_t'(gpio_in[9:8]);

    // add keeps its carry in bit 4, subtract wraps modulo 32,
    // the logic ops only ever fill the low nibble
    always_comb begin
        case (op)
            ALU_ADD: result_next = {1'b0, op_a} + {1'b0, op_b};
            ALU_SUB: result_next = {1'b0, op_a} - {1'b0, op_b};
            ALU_AND: result_next = {1'b0, op_a & op_b};
            ALU_XOR: result_next = {1'b0, op_a ^ op_b};
            default: result_next = '0;
        endcase
    end

    // one cycle of latency from pins to result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result <= result_next;
        end
    end

    always_comb begin
        gpio_out        = '0;
        gpio_out[20:16] = result;
        gpio_oeb        = OEB_MAP;
    end

    // a logic op seen at one edge leaves no carry bit in the next result
    assert property (@(posedge clk) disable iff (!rst_n)
        (op == ALU_AND || op == ALU_XOR) |=> (result[4] == 1'b0));

endmodule

// ==== hw/integrated_designs.sv ====
`timescale 1ns/100ps
`include "chip_consts.svh"

module integrated_designs (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [3:0]      design_select,
    input  chip_pkg::gpio_t gpio_in,
    output chip_pkg::gpio_t gpio_out,
    output chip_pkg::gpio_t gpio_oeb
);

    import chip_pkg::*;

    // slots count from 1 so that slot k answers to design_select == k
    gpio_t designs_gpio_out [1:`NUM_DESIGNS];
    gpio_t designs_gpio_oeb [1:`NUM_DESIGNS];

    // active low chip select, at most one bit low at a time
    logic [`NUM_DESIGNS:1] designs_cs;

    // active low reset for each slot, driven by the router
    logic [`NUM_DESIGNS:1] designs_rst_n;

    // select 0 and anything above the last slot leave every cs high
    always_comb begin
        designs_cs = '1;
        for (int k = 1; k <= `NUM_DESIGNS; k++) begin
            if (design_select == 4'(k)) begin
                designs_cs[k] = 1'b0;
            end
        end
    end

    // with no slot selected the whole bank is turned into inputs
    // and gpio_out is held at zero, otherwise the selected slot owns the pins
    always_comb begin
        gpio_out = '0;
        gpio_oeb = '1;
        for (int k = 1; k <= `NUM_DESIGNS; k++) begin
            if (!designs_cs[k]) begin
                gpio_out = designs_gpio_out[k];
                gpio_oeb = designs_gpio_oeb[k];
            end
        end
    end

    reset_router design_reset (
        .clk,
        .rst_n,
        .designs_cs,
        .designs_rst_n
    );

    // gpio_in fans out to every slot, the unselected ones sit in reset
    counter_design design_1 (
        .clk      (clk),
        .rst_n    (designs_rst_n[1]),
        .gpio_in  (gpio_in),
        .gpio_out (designs_gpio_out[1]),
        .gpio_oeb (designs_gpio_oeb[1])
    );

    lfsr_design design_2 (
        .clk      (clk),
        .rst_n    (designs_rst_n[2]),
        .gpio_in  (gpio_in),
        .gpio_out (designs_gpio_out[2]),
        .gpio_oeb (designs_gpio_oeb[2])
    );

    alu_design design_3 (
        .clk      (clk),
        .rst_n    (designs_rst_n[3]),
        .gpio_in  (gpio_in),
        .gpio_out (designs_gpio_out[3]),
        .gpio_oeb (designs_gpio_oeb[3])
    );

    // the decode must never select two slots at once
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(~designs_cs));

    // a select held steady for RESET_HOLD+1 edges has its slot running,
    // which ties the decode here to the sequencing inside the router
    for (genvar g = 1; g <= `NUM_DESIGNS; g++) begin : g_release_check
        assert property (@(posedge clk) disable iff (!rst_n)
            (!designs_cs[g]) [*(`RESET_HOLD + 1)]
            |=> (design_reset.slot_state[g] == SLOT_RUN));
    end

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk
);

    // half of the 40 ns clock period
    localparam int HALF_PERIOD = 20;

    // starts low so the first rising edge lands at 20 ns
    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule

// ==== sim/tb_integrated_designs.sv ====
`timescale 1ns/100ps
`include "chip_consts.svh"

module tb_integrated_designs;

    import chip_pkg::*;

    // edges a freshly selected slot gets to show activity before we give up
    localparam int RELEASE_LIMIT = 4 * `RESET_HOLD + 8;

    logic        clk;
    logic        rst_n;
    logic [3:0]  design_select;
    gpio_t       gpio_in;
    gpio_t       gpio_out;
    gpio_t       gpio_oeb;

    // cycle level reference model of the router and the three designs
    slot_state_t m_state [1:`NUM_DESIGNS];
    int          m_hold  [1:`NUM_DESIGNS];
    logic [7:0]  m_count;
    logic [15:0] m_lfsr;
    logic [4:0]  m_result;
    logic [3:0]  ops_seen;
    logic        wrap_seen;
    logic [31:0] lcg_state;
    // gpio_out as sampled at the last falling edge
    gpio_t       last_out;

    tb_clock_gen clock_gen (
        .clk (clk)
    );

    integrated_designs UUT (
        .clk,
        .rst_n,
        .design_select,
        .gpio_in,
        .gpio_out,
        .gpio_oeb
    );

    // 32-bit LCG, the low bits cycle too quickly so they are dropped
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;
    endfunction

    function automatic gpio_t rand_gpio();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return gpio_t'({hi[23:0], lo[23:0]});
    endfunction

    // enable high, clear low and an ADD with an odd operand a, so every
    // design shows a value different from its reset value once it runs
    function automatic gpio_t release_stim();
        gpio_t v;
        v       = rand_gpio();
        v[1:0]  = 2'b01;
        v[9:8]  = 2'b00;
        return v;
    endfunction

    // the mux follows the select in the same cycle, anything but 1..3 is all inputs
    function automatic gpio_t expected_out();
        gpio_t v;
        v = '0;
        case (design_select)
            4'd1: v[15:8] = m_count;
            4'd2: v[31:16] = m_lfsr;
            4'd3: v[20:16] = m_result;
            default: v = '0;
        endcase
        return v;
    endfunction

    function automatic gpio_t expected_oeb();
        gpio_t v;
        v = '1;
        case (design_select)
            4'd1: v[15:8] = '0;
            4'd2: v[31:16] = '0;
            4'd3: v[20:16] = '0;
            default: v = '1;
        endcase
        return v;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_gpio_out(input gpio_t actual, input gpio_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] gpio_out: got 0x%09h, expected 0x%09h",
                                actual, expected));
        end
    endtask

    task automatic check_gpio_oeb(input gpio_t actual, input gpio_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] gpio_oeb: got 0x%09h, expected 0x%09h",
                                actual, expected));
        end
    endtask

    // advance the model by the rising edge that just passed, using the
    // inputs that were applied during that cycle
    task automatic model_edge();
        logic       was_run [1:`NUM_DESIGNS];
        logic [3:0] a;
        logic [3:0] b;
        alu_op_t    op;
        for (int k = 1; k <= `NUM_DESIGNS; k++) begin
            was_run[k] = rst_n && (m_state[k] == SLOT_RUN);
            if (!rst_n || design_select != 4'(k)) begin
                m_state[k] = SLOT_HELD;
                m_hold[k]  = 0;
            end else if (m_state[k] == SLOT_HELD) begin
                m_state[k] = SLOT_WAIT;
                m_hold[k]  = 0;
            end else if (m_state[k] == SLOT_WAIT) begin
                // leaves wait on the (RESET_HOLD+1)th edge after selection
                if (m_hold[k] == `RESET_HOLD - 1) begin
                    m_state[k] = SLOT_RUN;
                end else begin
                    m_hold[k] = m_hold[k] + 1;
                end
            end
        end
        // a design only counts the edge if it was already out of reset
        if (was_run[1]) begin
            if (gpio_in[1]) begin
                m_count = '0;
            end else if (gpio_in[0]) begin
                wrap_seen = wrap_seen | (m_count == 8'hFF);
                m_count   = m_count + 8'd1;
            end
        end
        if (was_run[2] && gpio_in[0]) begin
            m_lfsr = (m_lfsr >> 1) ^ (m_lfsr[0] ? `LFSR_TAPS : 16'h0000);
        end
        if (was_run[3]) begin
            a  = gpio_in[3:0];
            b  = gpio_in[7:4];
            op = alu_op_t'(gpio_in[9:8]);
            ops_seen[op] = 1'b1;
            case (op)
                ALU_ADD: m_result = 5'(a) + 5'(b);
                ALU_SUB: m_result = 5'(a) - 5'(b);
                ALU_AND: m_result = 5'(a & b);
                default: m_result = 5'(a ^ b);
            endcase
        end
        // the router reset is asynchronous, so a slot that is not running
        // sits at its reset value right after the edge
        if (m_state[1] != SLOT_RUN) m_count = '0;
        if (m_state[2] != SLOT_RUN) m_lfsr = `LFSR_SEED;
        if (m_state[3] != SLOT_RUN) m_result = '0;
    endtask

    // outputs are checked on the falling edge, then the next inputs go out
    task automatic step_cycle(input logic [3:0] next_select, input gpio_t next_in,
                              input logic next_rst_n);
        @(negedge clk);
        model_edge();
        last_out = gpio_out;
        check_gpio_out(gpio_out, expected_out());
        check_gpio_oeb(gpio_oeb, expected_oeb());
        design_select = next_select;
        gpio_in       = next_in;
        rst_n         = next_rst_n;
    endtask

    // selects slot s and waits until its output moves away from held_value,
    // the design must show its first change on edge RESET_HOLD+2
    task automatic wait_for_release(input logic [3:0] s, input gpio_t held_value);
        int   edges;
        logic done;
        edges = 0;
        done  = 1'b0;
        step_cycle(s, release_stim(), 1'b1);
        while (!done) begin
            step_cycle(s, release_stim(), 1'b1);
            edges = edges + 1;
            if (last_out !== held_value) begin
                done = 1'b1;
            end else if (edges >= RELEASE_LIMIT) begin
                abort_run($sformatf("slot %0d never came out of reset after %0d edges",
                                    s, edges));
            end
        end
        if (edges != `RESET_HOLD + 2) begin
            abort_run($sformatf("[ERROR] release_edges: got 0x%0h, expected 0x%0h",
                                edges, `RESET_HOLD + 2));
        end
    endtask

    // clear_mode 0 leaves pin 1 random, 1 never clears, 2 clears rarely
    task automatic run_cycles(input logic [3:0] s, input int n, input int clear_mode);
        gpio_t       v;
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            v = rand_gpio();
            r = next_rand();
            if (clear_mode == 1) begin
                v[1] = 1'b0;
            end else if (clear_mode == 2) begin
                v[1] = (r[3:0] == 4'd0);
            end
            step_cycle(s, v, 1'b1);
        end
    endtask

    // selects 0 and 4..15 only, none of them may reach a design
    task automatic run_idle(input int n);
        logic [31:0] r;
        logic [3:0]  s;
        for (int i = 0; i < n; i++) begin
            r = next_rand() % 13;
            s = (r == 0) ? 4'd0 : 4'(r + 3);
            step_cycle(s, rand_gpio(), 1'b1);
        end
    endtask

    // random select hopping, each new select starts its own hold sequence
    task automatic run_mixed(input int n);
        logic [31:0] r;
        logic [3:0]  s;
        s = design_select;
        for (int i = 0; i < n; i++) begin
            r = next_rand();
            if (r[3:0] == 4'd0) begin
                s = r[7:4];
            end
            step_cycle(s, rand_gpio(), 1'b1);
        end
    endtask

    initial begin
        lcg_state     = 32'd12146;
        rst_n         = 1'b0;
        design_select = 4'd0;
        gpio_in       = '0;
        last_out      = '0;
        m_count       = '0;
        m_lfsr        = `LFSR_SEED;
        m_result      = '0;
        ops_seen      = '0;
        wrap_seen     = 1'b0;
        for (int k = 1; k <= `NUM_DESIGNS; k++) begin
            m_state[k] = SLOT_HELD;
            m_hold[k]  = 0;
        end
        // reset stays low for 16 rising edges
        for (int i = 0; i < 16; i++) begin
            step_cycle(4'd0, '0, i == 15);
        end
        run_idle(60);
        // counter, with a long run without clears so that it wraps
        wait_for_release(4'd1, '0);
        run_cycles(4'd1, 700, 1);
        run_cycles(4'd1, 150, 2);
        if (!wrap_seen) begin
            abort_run("the counter never wrapped past 0xff during the enable run");
        end
        wait_for_release(4'd2, gpio_t'(`LFSR_SEED) << 16);
        run_cycles(4'd2, 200, 0);
        // going away and back must restart both designs from reset
        wait_for_release(4'd1, '0);
        run_cycles(4'd1, 40, 2);
        wait_for_release(4'd2, gpio_t'(`LFSR_SEED) << 16);
        run_cycles(4'd2, 40, 0);
        // chip reset in the middle of a run, released by wait_for_release
        for (int i = 0; i < 4; i++) begin
            step_cycle(4'd2, rand_gpio(), 1'b0);
        end
        wait_for_release(4'd2, gpio_t'(`LFSR_SEED) << 16);
        run_cycles(4'd2, 40, 0);
        wait_for_release(4'd3, '0);
        run_cycles(4'd3, 300, 0);
        if (ops_seen != 4'hF) begin
            abort_run("not every ALU opcode was applied while the ALU was running");
        end
        run_mixed(400);
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+hw
hw/chip_pkg.sv
hw/reset_router.sv
hw/counter_design.sv
hw/lfsr_design.sv
hw/alu_design.sv
hw/integrated_designs.sv
sim/tb_clock_gen.sv
sim/tb_integrated_designs.sv
